// ==== Bender.yml ====
package:
  name: ppu_frame

sources:
  - common/ppu_pkg.sv
  - timing/frame_timing.sv
  - regs/ppu_regs.sv
  - palette/pal_ram.sv
  - pixel/pixel_mux.sv
  - design/ppu_top.sv
  - target: test
    files:
      - bench/ppu_tb.sv

// ==== all.f ====
common/ppu_pkg.sv
timing/frame_timing.sv
regs/ppu_regs.sv
palette/pal_ram.sv
pixel/pixel_mux.sv
design/ppu_top.sv
bench/ppu_tb.sv

// ==== bench/ppu_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module ppu_tb;
    import ppu_pkg::*;

    localparam int DOTS_PER_LINE   = 40;
    localparam int LINES_PER_FRAME = 8;
    localparam int VISIBLE_LINES   = 4;
    localparam int SCREEN_WIDTH    = 16;

    logic       clk, rst_n, dot_en, sp_prio, sp_zero, reg_en, reg_rw, nmi_n, pixel_valid;
    color_idx_t bg_idx, sp_idx;
    reg_sel_t   reg_sel;
    logic [7:0] reg_data_in, reg_data_out;
    nes_color_t pixel;
    dot_t       pixel_x;

    // model of counters, registers, flags and palette
    int         m_col = 0, m_row = 0, m_px = 0, frames = 0, pix_count = 0;
    logic       m_nmi_en = 1'b0, m_vbl = 1'b0, m_sp0 = 1'b0, m_pv = 1'b0;
    logic [4:0] m_mask = '0, m_paddr = '0;
    logic [7:0] m_rd = '0;
    nes_color_t m_pix = '0;
    nes_color_t m_pal [32] = '{default: '0};

    integer     seed = 32'hd7c7_bfb6;
    string      test_name;
    int         test_errs = 0, err_total = 0, tests_run = 0, tests_failed = 0;
    logic       timed_out = 1'b0;

    ppu_top #(
        .DOTS_PER_LINE(DOTS_PER_LINE), .LINES_PER_FRAME(LINES_PER_FRAME),
        .VISIBLE_LINES(VISIBLE_LINES), .SCREEN_WIDTH(SCREEN_WIDTH)
    ) dut_i (.*);

    // line 0 pre-render, then the visible lines, one post-render line, vblank
    function automatic vs_state_t phase_of(input int row);
        if (row == 0) return PRE_SL;
        if (row <= VISIBLE_LINES) return VIS_SL;
        return (row == VISIBLE_LINES + 1) ? POST_SL : VBLANK_SL;
    endfunction

    function automatic int pal_slot(input logic [4:0] a);
        return (a[1:0] == 2'b00) ? int'(a[3:0]) : int'(a);  // sprite backdrops alias bg
    endfunction

    task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // drive at the falling edge, update the model at the rising edge, check at the next fall
    task automatic step(input logic en, input logic rw, input reg_sel_t sel,
                        input logic [7:0] din);
        logic [31:0] r;
        logic        render, rd, bg_op, sp_op, frame_done;
        color_idx_t  bg_m, sp_m;
        vs_state_t   ph;
        r = $random(seed);
        {sp_zero, sp_prio, sp_idx, bg_idx} = r[9:0];
        dot_en = r[11:10] != 2'b00;  // about 3 in 4 cycles
        {reg_en, reg_rw, reg_sel, reg_data_in} = {en, rw, sel, din};
        @(posedge clk);
        ph     = phase_of(m_row);
        render = dot_en && ph == VIS_SL && m_col < SCREEN_WIDTH;
        rd     = reg_en && !reg_rw && reg_sel == REG_STATUS;
        bg_m   = (m_mask[MASK_BG_EN] && (m_col >= 8 || m_mask[MASK_BG_LEFT])) ? bg_idx : '0;
        sp_m   = (m_mask[MASK_SP_EN] && (m_col >= 8 || m_mask[MASK_SP_LEFT])) ? sp_idx : '0;
        bg_op  = bg_m[1:0] != 2'b00;
        sp_op  = sp_m[1:0] != 2'b00;
        m_pv   = render;
        if (render) begin
            m_px  = m_col;
            m_pix = (sp_op && (!bg_op || !sp_prio)) ? m_pal[pal_slot({1'b1, sp_m})]
                                                    : m_pal[pal_slot({1'b0, bg_m})];
            if (m_mask[MASK_GREY]) m_pix = m_pix & GREY_MASK;
        end
        if (rd) m_rd = {m_vbl, m_sp0, 6'h00};  // old flags go out
        if (dot_en && m_col == 0 && ph == PRE_SL) {m_vbl, m_sp0} = 2'b00;
        else if (dot_en && m_col == 0 && ph == POST_SL) m_vbl = 1'b1;
        else if (rd) m_vbl = 1'b0;
        if (render && sp_zero && bg_op && sp_op && m_col < SCREEN_WIDTH - 1) m_sp0 = 1'b1;
        if (reg_en && reg_rw) begin
            case (reg_sel)
                REG_CTRL:     m_nmi_en = reg_data_in[CTRL_NMI_EN];
                REG_MASK:     m_mask = reg_data_in[4:0];
                REG_PAL_ADDR: m_paddr = reg_data_in[4:0];
                REG_PAL_DATA: begin
                    m_pal[pal_slot(m_paddr)] = reg_data_in[5:0];
                    m_paddr++;
                end
                default: ;
            endcase
        end
        if (dot_en) begin
            m_col = (m_col + 1) % DOTS_PER_LINE;
            if (m_col == 0) m_row = (m_row + 1) % LINES_PER_FRAME;
        end
        frame_done = dot_en && m_col == 0 && m_row == 0;
        @(negedge clk);
        check_val("pixel_valid", m_pv, pixel_valid);
        if (m_pv) begin
            check_val("pixel_x", m_px, pixel_x);
            check_val("pixel", m_pix, pixel);
        end
        check_val("nmi_n", !(m_nmi_en && phase_of(m_row) == POST_SL && m_col < 3), nmi_n);
        check_val("status", m_rd, reg_data_out);
        pix_count += pixel_valid;
        if (frame_done) begin
            check_val("pixels per frame", SCREEN_WIDTH * VISIBLE_LINES, pix_count);
            pix_count = 0;
            frames++;
        end
    endtask

    // random steps until the phase is reached n_frames later
    task automatic run_to(input vs_state_t ph, input int n_frames, input logic with_regs);
        int          target, cycles;
        logic [31:0] r;
        target = frames + n_frames;
        cycles = 0;
        while (!timed_out && (frames < target || phase_of(m_row) != ph)) begin
            r = $random(seed);
            if (cycles > 1000 * (n_frames + 1)) begin
                $display("timeout in test %s: %s phase never reached", test_name, ph.name());
                timed_out = 1'b1;
                test_errs++;
            end else if (with_regs && r[3:0] == 4'd0)
                step(1'b1, r[4], r[4] ? reg_sel_t'(r[7:5] % 5) : REG_STATUS, r[15:8]);
            else
                step(1'b0, 1'b0, REG_CTRL, 8'h00);
            cycles++;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, test_errs);
        tests_run++;
        tests_failed += (test_errs != 0);
        err_total += test_errs;
        test_errs = 0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        {rst_n, dot_en, sp_prio, sp_zero, reg_en, reg_rw} = '0;
        {bg_idx, sp_idx, reg_sel, reg_data_in} = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        check_val("nmi_n", 1'b1, nmi_n);
        check_val("pixel_valid", 1'b0, pixel_valid);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        check_val("status", 8'h00, reg_data_out);
        end_test();

        // writes to 0x10..0x1c overwrite the bg backdrop entries
        test_name = "palette mirror";
        step(1'b1, 1'b1, REG_MASK, 8'h1e);
        step(1'b1, 1'b1, REG_PAL_ADDR, 8'h00);
        for (int i = 0; i < 32; i++) step(1'b1, 1'b1, REG_PAL_DATA, 8'($random(seed)));
        run_to(PRE_SL, 2, 1'b0);
        end_test();

        test_name = "vblank flag";
        run_to(VBLANK_SL, 0, 1'b0);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        check_val("vblank after post-render", 1'b1, reg_data_out[STAT_VBLANK]);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        check_val("vblank after read", 1'b0, reg_data_out[STAT_VBLANK]);
        run_to(VBLANK_SL, 1, 1'b0);
        run_to(VIS_SL, 0, 1'b0);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        check_val("vblank after pre-render", 1'b0, reg_data_out[STAT_VBLANK]);
        end_test();

        test_name = "nmi";
        step(1'b1, 1'b1, REG_CTRL, 8'h80);
        run_to(PRE_SL, 2, 1'b0);
        step(1'b1, 1'b1, REG_CTRL, 8'h00);
        run_to(PRE_SL, 2, 1'b0);
        end_test();

        test_name = "random traffic";
        run_to(PRE_SL, 8, 1'b1);
        end_test();

        test_name = "sprite zero";
        step(1'b1, 1'b1, REG_MASK, 8'h1e);
        run_to(VBLANK_SL, 1, 1'b0);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        run_to(VIS_SL, 0, 1'b0);
        step(1'b1, 1'b0, REG_STATUS, 8'h00);
        check_val("sprite zero after pre-render", 1'b0, reg_data_out[STAT_SP0]);
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
        if (tests_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    typedef logic [8:0] dot_t;        // column within a line
    typedef logic [8:0] line_t;       // scanline number
    typedef logic [3:0] color_idx_t;  // {palette select, pixel value}
    typedef logic [4:0] pal_addr_t;   // bit 4 set selects sprite palettes
    typedef logic [5:0] nes_color_t;  // system colour number
    typedef logic [2:0] reg_sel_t;

    // vertical phase of the frame
    typedef enum logic [1:0] {
        PRE_SL,
        VIS_SL,
        POST_SL,
        VBLANK_SL
    } vs_state_t;

    // register numbers on the cpu port
    localparam reg_sel_t REG_CTRL     = 3'd0;
    localparam reg_sel_t REG_MASK     = 3'd1;
    localparam reg_sel_t REG_STATUS   = 3'd2;
    localparam reg_sel_t REG_PAL_ADDR = 3'd3;
    localparam reg_sel_t REG_PAL_DATA = 3'd4;

    localparam int CTRL_NMI_EN = 7;

    // mask register bits
    localparam int MASK_GREY    = 0;
    localparam int MASK_BG_LEFT = 1;  // show bg in leftmost 8 columns
    localparam int MASK_SP_LEFT = 2;  // show sprites in leftmost 8 columns
    localparam int MASK_BG_EN   = 3;
    localparam int MASK_SP_EN   = 4;

    // status register bits
    localparam int STAT_SP0    = 6;
    localparam int STAT_VBLANK = 7;

    // greyscale keeps only the luma bits
    localparam nes_color_t GREY_MASK = 6'h30;

endpackage

`default_nettype wire

// ==== design/ppu_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module ppu_top #(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262,
    parameter int VISIBLE_LINES   = 240,
    parameter int SCREEN_WIDTH    = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dot_en,      // one strobe per dot
    input  ppu_pkg::color_idx_t  bg_idx,
    input  ppu_pkg::color_idx_t  sp_idx,
    input  logic                 sp_prio,     // 1 puts sprite behind bg
    input  logic                 sp_zero,
    input  logic                 reg_en,
    input  logic                 reg_rw,      // 1 write, 0 read
    input  ppu_pkg::reg_sel_t    reg_sel,
    input  logic [7:0]           reg_data_in,
    output logic [7:0]           reg_data_out,
    output logic                 nmi_n,
    output logic                 pixel_valid,
    output ppu_pkg::nes_color_t  pixel,
    output ppu_pkg::dot_t        pixel_x
);
    import ppu_pkg::*;

    dot_t       col;
    logic       render_dot;
    logic       vblank_set, flags_clr, sp0_set;
    logic       nmi_en;
    logic [4:0] mask;

    // palette write and pixel lookup ports
    logic       pal_wr;
    pal_addr_t  pal_wr_addr, pix_addr;
    nes_color_t pal_wr_data, pix_color;

    frame_timing #(
        .DOTS_PER_LINE  (DOTS_PER_LINE),
        .LINES_PER_FRAME(LINES_PER_FRAME),
        .VISIBLE_LINES  (VISIBLE_LINES),
        .SCREEN_WIDTH   (SCREEN_WIDTH)
    ) timing_i (
        .clk, .rst_n, .dot_en, .nmi_en,
        .col, .render_dot, .vblank_set, .flags_clr, .nmi_n
    );

    ppu_regs regs_i (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_data_in,
        .vblank_set, .flags_clr, .sp0_set,
        .reg_data_out, .nmi_en, .mask,
        .pal_wr, .pal_wr_addr, .pal_wr_data
    );

    pal_ram pal_i (
        .clk, .rst_n,
        .wr     (pal_wr),
        .wr_addr(pal_wr_addr),
        .wr_data(pal_wr_data),
        .rd_addr(pix_addr),
        .rd_data(pix_color)
    );

    pixel_mux #(
        .SCREEN_WIDTH(SCREEN_WIDTH)
    ) mux_i (
        .clk, .rst_n, .render_dot, .col, .mask,
        .bg_idx, .sp_idx, .sp_prio, .sp_zero,
        .pix_addr, .pix_color,
        .sp0_set, .pixel_valid, .pixel, .pixel_x
    );

endmodule

`default_nettype wire

// ==== palette/pal_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module pal_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr,
    input  ppu_pkg::pal_addr_t   wr_addr,
    input  ppu_pkg::nes_color_t  wr_data,
    input  ppu_pkg::pal_addr_t   rd_addr,
    output ppu_pkg::nes_color_t  rd_data
);
    import ppu_pkg::*;

    nes_color_t mem [32];

    // sprite backdrop slots alias the background ones
    function automatic pal_addr_t fold(input pal_addr_t a);
        pal_addr_t f;
        f = a;
        if (a[1:0] == 2'b00) f[4] = 1'b0;
        return f;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) mem[i] <= '0;
        end else if (wr) begin
            mem[fold(wr_addr)] <= wr_data;
        end
    end

    assign rd_data = mem[fold(rd_addr)];  // async read

endmodule

`default_nettype wire

// ==== pixel/pixel_mux.sv ====
`default_nettype none
`timescale 1ns/100ps

module pixel_mux #(
    parameter int SCREEN_WIDTH = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 render_dot,
    input  ppu_pkg::dot_t        col,
    input  logic [4:0]           mask,
    input  ppu_pkg::color_idx_t  bg_idx,
    input  ppu_pkg::color_idx_t  sp_idx,
    input  logic                 sp_prio,
    input  logic                 sp_zero,
    output ppu_pkg::pal_addr_t   pix_addr,
    input  ppu_pkg::nes_color_t  pix_color,
    output logic                 sp0_set,
    output logic                 pixel_valid,
    output ppu_pkg::nes_color_t  pixel,
    output ppu_pkg::dot_t        pixel_x
);
    import ppu_pkg::*;

    logic       left_col;
    logic       bg_show, sp_show;
    logic       bg_opaque, sp_opaque;
    color_idx_t bg_m, sp_m;
    nes_color_t color_out;

    assign left_col = col < 9'd8;

    // enables and left-edge clip
    assign bg_show = mask[MASK_BG_EN] && (!left_col || mask[MASK_BG_LEFT]);
    assign sp_show = mask[MASK_SP_EN] && (!left_col || mask[MASK_SP_LEFT]);
    assign bg_m    = bg_show ? bg_idx : '0;
    assign sp_m    = sp_show ? sp_idx : '0;

    assign bg_opaque = bg_m[1:0] != 2'b00;
    assign sp_opaque = sp_m[1:0] != 2'b00;

    // sprite wins unless transparent or behind an opaque bg
    always_comb begin
        if (sp_opaque && (!bg_opaque || !sp_prio)) pix_addr = {1'b1, sp_m};
        else pix_addr = {1'b0, bg_m};
    end

    // no hit on the last column
    assign sp0_set = render_dot && sp_zero && bg_opaque && sp_opaque &&
                     col < dot_t'(SCREEN_WIDTH - 1);

    assign color_out = mask[MASK_GREY] ? (pix_color & GREY_MASK) : pix_color;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pixel_valid <= 1'b0;
        else pixel_valid <= render_dot;
    end

    always_ff @(posedge clk) begin
        if (render_dot) begin
            pixel   <= color_out;
            pixel_x <= col;
        end
    end

    // render_dot comes from the frame counters
    a_pix_x: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> pixel_x < dot_t'(SCREEN_WIDTH));

endmodule

`default_nettype wire

// ==== regs/ppu_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module ppu_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 reg_en,
    input  logic                 reg_rw,
    input  ppu_pkg::reg_sel_t    reg_sel,
    input  logic [7:0]           reg_data_in,
    input  logic                 vblank_set,
    input  logic                 flags_clr,
    input  logic                 sp0_set,
    output logic [7:0]           reg_data_out,
    output logic                 nmi_en,
    output logic [4:0]           mask,
    output logic                 pal_wr,
    output ppu_pkg::pal_addr_t   pal_wr_addr,
    output ppu_pkg::nes_color_t  pal_wr_data
);
    import ppu_pkg::*;

    logic       wr_en, status_rd;
    logic       vblank, sp0_hit;
    logic [7:0] status;
    pal_addr_t  pal_addr;

    assign wr_en     = reg_en && reg_rw;
    assign status_rd = reg_en && !reg_rw && reg_sel == REG_STATUS;

    // ctrl, mask and the palette pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_en   <= 1'b0;
            mask     <= '0;
            pal_addr <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                REG_CTRL:     nmi_en   <= reg_data_in[CTRL_NMI_EN];
                REG_MASK:     mask     <= reg_data_in[4:0];
                REG_PAL_ADDR: pal_addr <= reg_data_in[4:0];
                REG_PAL_DATA: pal_addr <= pal_addr + 1'b1;  // wraps at 32
                default:      ;
            endcase
        end
    end

    // palette ram folds the backdrop mirrors itself
    assign pal_wr      = wr_en && reg_sel == REG_PAL_DATA;
    assign pal_wr_addr = pal_addr;
    assign pal_wr_data = reg_data_in[5:0];

    // frame clear beats set, set beats a status read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank  <= 1'b0;
            sp0_hit <= 1'b0;
        end else begin
            if (flags_clr) vblank <= 1'b0;
            else if (vblank_set) vblank <= 1'b1;
            else if (status_rd) vblank <= 1'b0;

            if (flags_clr) sp0_hit <= 1'b0;
            else if (sp0_set) sp0_hit <= 1'b1;
        end
    end

    always_comb begin
        status = '0;
        status[STAT_VBLANK] = vblank;
        status[STAT_SP0]    = sp0_hit;
    end

    // read data held until the next status read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) reg_data_out <= '0;
        else if (status_rd) reg_data_out <= status;
    end

    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        reg_en |-> reg_sel <= REG_PAL_DATA);

endmodule

`default_nettype wire

// ==== timing/frame_timing.sv ====
`default_nettype none
`timescale 1ns/100ps

module frame_timing #(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262,
    parameter int VISIBLE_LINES   = 240,
    parameter int SCREEN_WIDTH    = 256
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dot_en,
    input  logic           nmi_en,
    output ppu_pkg::dot_t  col,
    output logic           render_dot,
    output logic           vblank_set,
    output logic           flags_clr,
    output logic           nmi_n
);
    import ppu_pkg::*;

    localparam dot_t  LAST_DOT  = dot_t'(DOTS_PER_LINE - 1);
    localparam line_t LAST_LINE = line_t'(LINES_PER_FRAME - 1);
    localparam line_t VIS_LAST  = line_t'(VISIBLE_LINES);
    localparam line_t POST_LINE = line_t'(VISIBLE_LINES + 1);

    line_t     row;
    vs_state_t state, state_nxt;
    logic      last_dot;

    assign last_dot = (col == LAST_DOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (dot_en) begin
            if (last_dot) begin
                col <= '0;
                row <= (row == LAST_LINE) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // phase changes on the last dot of each boundary line
    always_comb begin
        state_nxt = state;
        case (state)
            PRE_SL:    if (last_dot && row == '0) state_nxt = VIS_SL;
            VIS_SL:    if (last_dot && row == VIS_LAST) state_nxt = POST_SL;
            POST_SL:   if (last_dot && row == POST_LINE) state_nxt = VBLANK_SL;
            VBLANK_SL: if (last_dot && row == LAST_LINE) state_nxt = PRE_SL;
            default:   state_nxt = PRE_SL;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= PRE_SL;
        else if (dot_en) state <= state_nxt;
    end

    assign render_dot = dot_en && state == VIS_SL && col < dot_t'(SCREEN_WIDTH);
    assign vblank_set = dot_en && state == POST_SL && col == '0;  // first dot of post-render
    assign flags_clr  = dot_en && state == PRE_SL && col == '0;

    // short active-low pulse at the start of post-render
    assign nmi_n = !(nmi_en && state == POST_SL && col < 9'd3);

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        col < dot_t'(DOTS_PER_LINE));

    // phase register must track the row counter
    a_vis_rows: assert property (@(posedge clk) disable iff (!rst_n)
        (state == VIS_SL) == (row >= 9'd1 && row <= VIS_LAST));

endmodule

`default_nettype wire
